// ==== drain_input.txt ====
# kind arg(hex: beats offered, command word, or idle cycles) pulse(grant/reject/error/none)
# then expected data_available wr_almost_full rd_empty rd_almost_empty after the step
check 0 none 0 0 1 1
beats 1 none 1 0 0 1
beats 3 none 4 0 0 0
cmd 4000 reject 4 0 0 0
cmd 4005 reject 4 0 0 0
cmd 4003 grant 1 0 0 1
cmd 00FF none 1 0 0 1
cmd C000 error 1 0 0 1
cmd 7F01 grant 0 0 1 1
beats 14 none 16 1 0 0
beats 2 none 16 1 0 0
cmd 40FF reject 16 1 0 0
drainwr 4004 grant 12 0 0 0
cmd 400C grant 0 0 1 1
beats A none 10 0 0 0
cmd 8304 none 10 1 0 0
drainwr 4007 grant 4 0 0 1
drainwr 4005 reject 5 0 0 0
cmd 8000 none 5 0 0 0
beats B none 16 1 0 0
cmd 4010 grant 0 0 1 1
cmd BFFF none 0 1 1 1
drainwr 4001 reject 1 1 0 1
cmd C0AB error 1 1 0 1
cmd 8081 none 1 0 0 1
check 3 none 1 0 0 1

// ==== all.f ====
drain_pkg.sv
drain_cmd_decode.sv
drain_space_tracker.sv
drain_status_flags.sv
drain_ctrl_top.sv
tb_drain_ctrl.sv

// ==== Makefile ====
# Verilator flow for the drain-control subsystem

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP_TB    ?= tb_drain_ctrl
TOP_RTL   ?= drain_ctrl_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= NO ERRORS

.PHONY: all lint sim clean

all: sim

# Lint the RTL from its top level
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP_RTL)

# Build and run; pass only when the pass line is printed
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP_TB) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP_TB))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_drain_ctrl.sv ====
`timescale 1ns/1ps

module tb_drain_ctrl;

    localparam int DEPTH   = 16;            // Small so full is easy to reach
    localparam int OW      = $clog2(DEPTH) + 1;
    localparam int TIMEOUT = 20;            // Cycles allowed for a pulse
    localparam int QUIET   = 4;             // Window where no pulse may show

    // ----------------------------------------
    // DUT signals
    // ----------------------------------------
    logic                  axi_aclk;
    logic                  reset;
    logic                  wr_valid;
    logic                  wr_ready;
    logic                  cmd_valid;
    drain_pkg::drain_cmd_t cmd_word;
    logic                  drain_grant;
    logic                  drain_reject;
    logic                  cmd_error;
    logic [OW-1:0]         data_available;
    logic                  wr_almost_full;
    logic                  rd_empty;
    logic                  rd_almost_empty;

    // Reference model state
    int model_occ;          // Beats present
    int model_af;           // Almost-full margin
    int model_ae;           // Almost-empty margin
    int error_count;
    int step_count;

    drain_ctrl_top #(
        .DEPTH (DEPTH)
    ) dut (
        .axi_aclk        (axi_aclk),
        .reset           (reset),
        .wr_valid        (wr_valid),
        .wr_ready        (wr_ready),
        .cmd_valid       (cmd_valid),
        .cmd_word        (cmd_word),
        .drain_grant     (drain_grant),
        .drain_reject    (drain_reject),
        .cmd_error       (cmd_error),
        .data_available  (data_available),
        .wr_almost_full  (wr_almost_full),
        .rd_empty        (rd_empty),
        .rd_almost_empty (rd_almost_empty)
    );

    always #4 axi_aclk = ~axi_aclk;         // 8 ns period

    // ----------------------------------------
    // Compare and failure helpers
    // ----------------------------------------
    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            error_count++;
            $display("ERROR at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "%s", what);
    endtask

    // Pulses as {grant, reject, error}
    function automatic int read_pulses();
        return int'({drain_grant, drain_reject, cmd_error});
    endfunction

    function automatic int decode_pulse_token(input logic [63:0] tok);
        if (tok == 64'("grant"))  return 4;
        if (tok == 64'("reject")) return 2;
        if (tok == 64'("error"))  return 1;
        if (tok == 64'("none"))   return 0;
        return -1;                          // Unknown word
    endfunction

    // ----------------------------------------
    // Step drivers
    // ----------------------------------------
    task automatic run_beats(input int count);
        int lagged;                         // data_available trails occupancy by one edge
        lagged = model_occ;
        for (int i = 0; i < count; i++) begin
            @(negedge axi_aclk);
            check_value("wr_ready", int'(model_occ < DEPTH), int'(wr_ready));
            check_value("data_available", lagged, int'(data_available));
            lagged   = model_occ;
            wr_valid = 1'b1;
            if (model_occ < DEPTH) model_occ++;     // Ignored while full
        end
        @(negedge axi_aclk);
        wr_valid = 1'b0;
    endtask

    // One command, optionally with a write beat landing on the drain edge
    task automatic run_command(input logic [15:0] word, input logic with_beat,
                               input int exp_pulse);
        logic [1:0] op;
        logic       beat_ok;
        int         size;
        int         want;                   // Pulse the model predicts
        int         want_lat;
        int         lat;
        int         limit;
        int         pulses;
        op       = word[15:14];
        size     = int'(word[7:0]);
        want     = 0;
        want_lat = 0;
        beat_ok  = 1'b0;
        case (op)
            2'd1: begin
                want     = (size >= 1 && size <= model_occ) ? 4 : 2;
                want_lat = 2;
            end
            2'd3: begin
                want     = 1;
                want_lat = 1;
            end
            default: ;                      // NOP and margin give no pulse
        endcase
        check_value("model pulse", exp_pulse, want);

        @(negedge axi_aclk);
        cmd_valid = 1'b1;
        cmd_word  = word;
        lat       = 0;
        pulses    = 0;
        limit     = (want == 0) ? QUIET : TIMEOUT;
        while (pulses == 0 && lat < limit) begin
            @(negedge axi_aclk);
            if (lat == 0) cmd_valid = 1'b0;     // Sampled at edge N
            if (lat == 1 && with_beat) begin    // Beat meets the drain edge
                check_value("wr_ready", int'(model_occ < DEPTH), int'(wr_ready));
                beat_ok  = (model_occ < DEPTH);
                wr_valid = 1'b1;
            end
            if (lat == 2) wr_valid = 1'b0;
            pulses = read_pulses();
            if (pulses == 0) lat++;
        end
        cmd_valid = 1'b0;
        wr_valid  = 1'b0;
        if (want != 0 && pulses == 0) begin
            report_failure("Timed out waiting for a grant, reject or error pulse");
        end
        check_value("command pulses", want, pulses);
        if (pulses != 0) check_value("pulse latency", want_lat, lat);

        // Model update with the drain checked against pre-beat occupancy
        if (beat_ok) model_occ++;
        if (want == 4) model_occ -= size;
        if (op == 2'd2) begin
            model_af = int'(word[13:7]);
            model_ae = int'(word[6:0]);
        end
    endtask

    task automatic check_status(input int exp_avail, input int exp_af,
                                input int exp_empty, input int exp_ae);
        // Registered status settles while every pulse stays low
        for (int i = 0; i < 2; i++) begin
            @(negedge axi_aclk);
            check_value("idle pulses", 0, read_pulses());
        end
        // File against model
        check_value("model data_available", exp_avail, model_occ);
        check_value("model wr_almost_full", exp_af, int'(model_occ + model_af >= DEPTH));
        check_value("model rd_empty", exp_empty, int'(model_occ == 0));
        check_value("model rd_almost_empty", exp_ae, int'(model_occ <= model_ae));
        // DUT against expected
        check_value("data_available", exp_avail, int'(data_available));
        check_value("wr_almost_full", exp_af, int'(wr_almost_full));
        check_value("rd_empty", exp_empty, int'(rd_empty));
        check_value("rd_almost_empty", exp_ae, int'(rd_almost_empty));
        check_value("wr_ready", int'(model_occ < DEPTH), int'(wr_ready));
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int               fd;
        int               code;
        int               exp_pulse;
        int               exp_avail;
        int               exp_af;
        int               exp_empty;
        int               exp_ae;
        logic [63:0]      kind_tok;
        logic [63:0]      pulse_tok;
        logic [15:0]      arg;
        logic [8*160-1:0] skip_line;
        axi_aclk    = 1'b0;
        reset       = 1'b1;
        wr_valid    = 1'b0;
        cmd_valid   = 1'b0;
        cmd_word    = '0;
        model_occ   = 0;
        model_af    = 1;                    // Margins out of reset
        model_ae    = 1;
        error_count = 0;
        step_count  = 0;

        fd = $fopen("drain_input.txt", "r");
        if (fd == 0) report_failure("Could not open drain_input.txt");

        repeat (5) @(posedge axi_aclk);
        @(negedge axi_aclk);
        reset = 1'b0;

        code = $fscanf(fd, "%s", kind_tok);
        while (code == 1) begin
            if (kind_tok == 64'("#")) begin
                code = $fgets(skip_line, fd);   // Comment line
            end else begin
                code = $fscanf(fd, "%h %s %d %d %d %d", arg, pulse_tok,
                               exp_avail, exp_af, exp_empty, exp_ae);
                if (code != 6) report_failure("Malformed step line in drain_input.txt");
                exp_pulse = decode_pulse_token(pulse_tok);
                if (exp_pulse < 0) report_failure("Unknown pulse word in drain_input.txt");
                if (kind_tok == 64'("beats")) begin
                    check_value("model pulse", exp_pulse, 0);
                    run_beats(int'(arg));
                end else if (kind_tok == 64'("cmd")) begin
                    run_command(arg, 1'b0, exp_pulse);
                end else if (kind_tok == 64'("drainwr")) begin
                    run_command(arg, 1'b1, exp_pulse);
                end else if (kind_tok == 64'("check")) begin
                    check_value("model pulse", exp_pulse, 0);
                    repeat (int'(arg)) @(negedge axi_aclk);
                end else begin
                    report_failure("Unknown step kind in drain_input.txt");
                end
                check_status(exp_avail, exp_af, exp_empty, exp_ae);
                step_count++;
            end
            code = $fscanf(fd, "%s", kind_tok);
        end
        $fclose(fd);
        if (step_count == 0) report_failure("No steps found in drain_input.txt");

        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_drain_ctrl

// ==== drain_ctrl_top.sv ====
`timescale 1ns/1ps

module drain_ctrl_top #(
    parameter int DEPTH = 512                           // Virtual FIFO depth
) (
    input  logic                       axi_aclk,
    input  logic                       reset,

    // Producer side
    input  logic                       wr_valid,        // One-beat strobe
    output logic                       wr_ready,        // Space left

    // Command side
    input  logic                       cmd_valid,
    input  drain_pkg::drain_cmd_t      cmd_word,
    output logic                       drain_grant,     // 2 cycles after command
    output logic                       drain_reject,
    output logic                       cmd_error,       // 1 cycle after command

    // Status
    output logic [$clog2(DEPTH):0]     data_available,
    output logic                       wr_almost_full,
    output logic                       rd_empty,
    output logic                       rd_almost_empty
);

    localparam int OW = $clog2(DEPTH) + 1;

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------
    logic          drain_req;       // Decode -> tracker
    logic [7:0]    drain_size;
    logic          margin_load;     // Decode -> status
    logic [6:0]    af_margin;
    logic [6:0]    ae_margin;
    logic [OW-1:0] occupancy;       // Tracker -> status

    // Command word decode
    drain_cmd_decode u_decode (
        .axi_aclk    (axi_aclk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_word    (cmd_word),
        .drain_req   (drain_req),
        .drain_size  (drain_size),
        .margin_load (margin_load),
        .af_margin   (af_margin),
        .ae_margin   (ae_margin),
        .cmd_error   (cmd_error)
    );

    // Occupancy and drain arbitration
    drain_space_tracker #(
        .DEPTH (DEPTH)
    ) u_tracker (
        .axi_aclk     (axi_aclk),
        .reset        (reset),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .drain_req    (drain_req),
        .drain_size   (drain_size),
        .occupancy    (occupancy),
        .drain_grant  (drain_grant),
        .drain_reject (drain_reject)
    );

    // Margins and flags
    drain_status_flags #(
        .DEPTH (DEPTH)
    ) u_status (
        .axi_aclk        (axi_aclk),
        .reset           (reset),
        .occupancy       (occupancy),
        .margin_load     (margin_load),
        .af_margin       (af_margin),
        .ae_margin       (ae_margin),
        .data_available  (data_available),
        .wr_almost_full  (wr_almost_full),
        .rd_empty        (rd_empty),
        .rd_almost_empty (rd_almost_empty)
    );

endmodule : drain_ctrl_top

// ==== drain_status_flags.sv ====
`timescale 1ns/1ps

module drain_status_flags #(
    parameter int DEPTH = 512               // Virtual FIFO depth in beats
) (
    input  logic                       axi_aclk,
    input  logic                       reset,
    input  logic [$clog2(DEPTH):0]     occupancy,          // From tracker
    input  logic                       margin_load,        // From decode
    input  logic [6:0]                 af_margin,
    input  logic [6:0]                 ae_margin,
    output logic [$clog2(DEPTH):0]     data_available,     // Registered occupancy
    output logic                       wr_almost_full,
    output logic                       rd_empty,
    output logic                       rd_almost_empty
);

    localparam int OW = $clog2(DEPTH) + 1;  // Occupancy width
    localparam int CW = OW + 8;             // Room for occupancy plus margin

    // ----------------------------------------
    // Margin registers
    // ----------------------------------------
    logic [6:0] af_q;
    logic [6:0] ae_q;

    always_ff @(posedge axi_aclk) begin
        if (reset) begin
            af_q <= drain_pkg::DEFAULT_AF_MARGIN;
            ae_q <= drain_pkg::DEFAULT_AE_MARGIN;
        end else if (margin_load) begin
            af_q <= af_margin;
            ae_q <= ae_margin;
        end
    end

    // New margins apply on the load edge itself
    logic [6:0] af_eff;
    logic [6:0] ae_eff;

    assign af_eff = margin_load ? af_margin : af_q;
    assign ae_eff = margin_load ? ae_margin : ae_q;

    // ----------------------------------------
    // Flag compares
    // ----------------------------------------
    logic [CW-1:0] occ_wide;
    logic          af_hit;
    logic          ae_hit;
    logic          empty_hit;

    assign occ_wide = CW'(occupancy);

    always_comb begin
        // occ >= DEPTH - af, rearranged to stay non-negative
        af_hit    = (occ_wide + CW'(af_eff)) >= CW'(DEPTH);
        ae_hit    = occ_wide <= CW'(ae_eff);
        empty_hit = (occupancy == '0);
    end

    // ----------------------------------------
    // Registered status
    // ----------------------------------------
    always_ff @(posedge axi_aclk) begin
        if (reset) begin
            data_available  <= '0;
            wr_almost_full  <= 1'b0;
            rd_empty        <= 1'b1;    // Nothing stored out of reset
            rd_almost_empty <= 1'b1;
        end else begin
            data_available  <= occupancy;   // One edge behind tracker
            wr_almost_full  <= af_hit;
            rd_empty        <= empty_hit;
            rd_almost_empty <= ae_hit;
        end
    end

endmodule : drain_status_flags

// ==== drain_space_tracker.sv ====
`timescale 1ns/1ps

module drain_space_tracker #(
    parameter int DEPTH = 512               // Virtual FIFO depth in beats
) (
    input  logic                       axi_aclk,
    input  logic                       reset,
    input  logic                       wr_valid,       // One-beat write strobe
    output logic                       wr_ready,       // Not full
    input  logic                       drain_req,      // From decode
    input  logic [7:0]                 drain_size,     // Beats requested
    output logic [$clog2(DEPTH):0]     occupancy,      // Beats present
    output logic                       drain_grant,    // Reservation accepted
    output logic                       drain_reject    // Reservation refused
);

    localparam int OW = $clog2(DEPTH) + 1;  // Occupancy width
    localparam int CW = OW + 8;             // Compare width, no overflow

    // ----------------------------------------
    // Local signals
    // ----------------------------------------
    logic [OW-1:0] occ_q;           // Occupancy register
    logic [OW-1:0] occ_next;
    logic [OW-1:0] drain_amt;       // Beats removed this edge
    logic [CW-1:0] size_wide;
    logic [CW-1:0] occ_wide;
    logic          full;
    logic          wr_beat;         // Accepted write beat
    logic          drain_fits;      // Size within occupancy
    logic          drain_ok;        // Granted this edge

    // ----------------------------------------
    // Write side
    // ----------------------------------------
    assign full     = (occ_wide >= CW'(DEPTH));
    assign wr_ready = !full;
    assign wr_beat  = wr_valid && wr_ready;     // Counts only when ready

    // ----------------------------------------
    // Drain check
    // ----------------------------------------
    // Both sides zero-extended so a 255 request can't wrap
    assign size_wide = CW'(drain_size);
    assign occ_wide  = CW'(occ_q);

    // Compared against occupancy before this edge's write beat
    always_comb begin
        drain_fits = (size_wide != '0) && (size_wide <= occ_wide);
        drain_ok   = drain_req && drain_fits;
    end

    // Only taken when granted, then size fits in OW bits
    assign drain_amt = drain_ok ? OW'(drain_size) : '0;

    // ----------------------------------------
    // Occupancy update
    // ----------------------------------------
    always_comb begin
        occ_next = occ_q;
        if (wr_beat) begin
            occ_next = occ_next + OW'(1);   // Single-beat fill
        end
        occ_next = occ_next - drain_amt;    // Never underflows, see check
    end

    always_ff @(posedge axi_aclk) begin
        if (reset) begin
            occ_q <= '0;
        end else begin
            occ_q <= occ_next;
        end
    end

    assign occupancy = occ_q;

    // ----------------------------------------
    // Grant / reject pulses
    // ----------------------------------------
    always_ff @(posedge axi_aclk) begin
        if (reset) begin
            drain_grant  <= 1'b0;
            drain_reject <= 1'b0;
        end else begin
            drain_grant  <= drain_ok;
            drain_reject <= drain_req && !drain_fits;   // Zero or too big
        end
    end

endmodule : drain_space_tracker

// ==== drain_cmd_decode.sv ====
`timescale 1ns/1ps

module drain_cmd_decode (
    input  logic                 axi_aclk,
    input  logic                 reset,
    input  logic                 cmd_valid,      // One-cycle command strobe
    input  drain_pkg::drain_cmd_t cmd_word,      // Raw command word
    output logic                 drain_req,      // To tracker
    output logic [7:0]           drain_size,
    output logic                 margin_load,    // To status block
    output logic [6:0]           af_margin,
    output logic [6:0]           ae_margin,
    output logic                 cmd_error       // Illegal opcode seen
);

    // ----------------------------------------
    // Input capture stage (edge N)
    // ----------------------------------------
    logic                  cmd_valid_q;
    drain_pkg::drain_cmd_t cmd_word_q;

    always_ff @(posedge axi_aclk) begin
        if (reset) begin
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= cmd_valid;
        end
    end

    always_ff @(posedge axi_aclk) begin
        cmd_word_q <= cmd_word;         // Payload, qualified by cmd_valid_q
    end

    // ----------------------------------------
    // Opcode decode
    // ----------------------------------------
    logic is_drain, is_margin, is_illegal;

    always_comb begin
        is_drain   = 1'b0;
        is_margin  = 1'b0;
        is_illegal = 1'b0;
        // Op lines up in both views, drain view used to pick
        case (cmd_word_q.drain.op)
            drain_pkg::OP_DRAIN:      is_drain   = cmd_valid_q;
            drain_pkg::OP_SET_MARGIN: is_margin  = cmd_valid_q;
            drain_pkg::OP_ILLEGAL:    is_illegal = cmd_valid_q;
            default: ;                  // OP_NOP, nothing to do
        endcase
    end

    // ----------------------------------------
    // Output stage (edge N+1)
    // ----------------------------------------
    always_ff @(posedge axi_aclk) begin
        if (reset) begin
            drain_req   <= 1'b0;
            margin_load <= 1'b0;
            cmd_error   <= 1'b0;
        end else begin
            drain_req   <= is_drain;
            margin_load <= is_margin;
            cmd_error   <= is_illegal;
        end
    end

    // Decoded fields ride along with the strobes
    always_ff @(posedge axi_aclk) begin
        drain_size <= cmd_word_q.drain.size;    // Reserved bits ignored
        af_margin  <= cmd_word_q.cfg.af_margin;
        ae_margin  <= cmd_word_q.cfg.ae_margin;
    end

endmodule : drain_cmd_decode

// ==== drain_pkg.sv ====
package drain_pkg;

    // ----------------------------------------
    // Command opcode
    // ----------------------------------------
    typedef enum logic [1:0] {
        OP_NOP        = 2'd0,   // No operation
        OP_DRAIN      = 2'd1,   // Reserve a burst of beats
        OP_SET_MARGIN = 2'd2,   // Reprogram almost-full / almost-empty margins
        OP_ILLEGAL    = 2'd3    // Flagged as a command error
    } drain_op_e;

    // ----------------------------------------
    // Command word views
    // ----------------------------------------

    // Drain view
    typedef struct packed {
        drain_op_e   op;        // [15:14]
        logic [5:0]  reserved;  // [13:8] don't care
        logic [7:0]  size;      // [7:0] beats to reserve
    } drain_req_t;

    // Configuration view
    typedef struct packed {
        drain_op_e   op;        // [15:14], same spot as drain view
        logic [6:0]  af_margin; // [13:7] almost-full margin
        logic [6:0]  ae_margin; // [6:0] almost-empty margin
    } margin_cfg_t;

    // One 16-bit word, decoded by op
    typedef union packed {
        drain_req_t  drain;
        margin_cfg_t cfg;
    } drain_cmd_t;

    // ----------------------------------------
    // Reset defaults for the margins
    // ----------------------------------------
    localparam logic [6:0] DEFAULT_AF_MARGIN = 7'd1;
    localparam logic [6:0] DEFAULT_AE_MARGIN = 7'd1;

endpackage : drain_pkg
